// ==== project.f ====
+incdir+verif
rtl/ikari_input_pkg.sv
rtl/player_ctrl_if.sv
rtl/joy_source_mapper.sv
rtl/cabinet_panel.sv
rtl/dip_switch_bank.sv
rtl/ikari_input_top.sv
verif/tb_ikari_input.sv

// ==== rtl/cabinet_panel.sv ====
// Cabinet panel with rotary step divider, rotary positions, player words and pause
`timescale 1ns/1ps

module cabinet_panel #(
	parameter int rot_div_w = 23
) (
	input  logic                                   clk_53p6,
	input  logic                                   arst_n,
	player_ctrl_if.snk                             p1,
	player_ctrl_if.snk                             p2,
	output logic [ikari_input_pkg::joy_w-1:0]      player1,
	output logic [ikari_input_pkg::joy_w-1:0]      player2,
	output logic                                   pause_req
);

	// ========================================================================
	// Helpers
	// ========================================================================
	// Left wins when both rotate buttons are held
	function automatic ikari_input_pkg::rot_dir_e rot_request(input logic rot_l,
	                                                          input logic rot_r);
		if (rot_l)
			return ikari_input_pkg::rot_ccw;
		else if (rot_r)
			return ikari_input_pkg::rot_cw;
		return ikari_input_pkg::rot_hold;
	endfunction

	// One step with wrap at both ends of the dial
	function automatic logic [ikari_input_pkg::rot_w-1:0] rot_step(
		input logic [ikari_input_pkg::rot_w-1:0] cur,
		input ikari_input_pkg::rot_dir_e         dir
	);
		logic [ikari_input_pkg::rot_w-1:0] last;
		last = ikari_input_pkg::rot_w'(ikari_input_pkg::rot_positions - 1);
		case (dir)
			ikari_input_pkg::rot_ccw: return (cur == last) ? '0 : cur + 1'b1;
			ikari_input_pkg::rot_cw:  return (cur == '0) ? last : cur - 1'b1;
			default:                  return cur;
		endcase
	endfunction

	// Buttons go out inverted, rotary field as is, spare bits high
	function automatic logic [ikari_input_pkg::joy_w-1:0] pack_word(
		input logic up, input logic down, input logic left, input logic right,
		input logic shot, input logic grenade, input logic start, input logic coin,
		input logic service, input logic [ikari_input_pkg::rot_w-1:0] rot
	);
		logic [ikari_input_pkg::joy_w-1:0] w;
		w = '1;
		w[ikari_input_pkg::pw_coin]    = ~coin;
		w[ikari_input_pkg::pw_start]   = ~start;
		w[ikari_input_pkg::pw_shot]    = ~shot;
		w[ikari_input_pkg::pw_grenade] = ~grenade;
		w[ikari_input_pkg::pw_rot_hi:ikari_input_pkg::pw_rot_lo] = rot;
		w[ikari_input_pkg::pw_service] = ~service;
		w[ikari_input_pkg::pw_left]    = ~left;
		w[ikari_input_pkg::pw_right]   = ~right;
		w[ikari_input_pkg::pw_down]    = ~down;
		w[ikari_input_pkg::pw_up]      = ~up;
		return w;
	endfunction

	// ========================================================================
	// Step divider and rotary positions
	// ========================================================================
	logic [rot_div_w-1:0]              div_q;
	logic                              rot_tick;
	ikari_input_pkg::rot_dir_e         dir1, dir2;
	logic [ikari_input_pkg::rot_w-1:0] rot1_q, rot2_q;
	logic [ikari_input_pkg::rot_w-1:0] rot1_nxt, rot2_nxt;

	// Tick once per divider wrap
	assign rot_tick = (div_q == '0);
	assign dir1     = rot_request(p1.rot_left, p1.rot_right);
	assign dir2     = rot_request(p2.rot_left, p2.rot_right);
	assign rot1_nxt = rot_tick ? rot_step(rot1_q, dir1) : rot1_q;
	assign rot2_nxt = rot_tick ? rot_step(rot2_q, dir2) : rot2_q;

	// Word takes next position so the field moves with the position register
	always_ff @(posedge clk_53p6 or negedge arst_n) begin
		if (!arst_n) begin
			div_q     <= '0;
			rot1_q    <= ikari_input_pkg::rot_home;
			rot2_q    <= ikari_input_pkg::rot_home;
			player1   <= pack_word(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0,
			                       ikari_input_pkg::rot_home);
			player2   <= pack_word(1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0,
			                       ikari_input_pkg::rot_home);
			pause_req <= 1'b0;
		end else begin
			div_q     <= div_q + 1'b1;
			rot1_q    <= rot1_nxt;
			rot2_q    <= rot2_nxt;
			player1   <= pack_word(p1.up, p1.down, p1.left, p1.right, p1.shot, p1.grenade,
			                       p1.start, p1.coin, p1.service, rot1_nxt);
			player2   <= pack_word(p2.up, p2.down, p2.left, p2.right, p2.shot, p2.grenade,
			                       p2.start, p2.coin, p2.service, rot2_nxt);
			// Either player can halt the game
			pause_req <= p1.pause | p2.pause;
		end
	end

	// Dial never leaves its twelve positions
	a_rot_range: assert property (@(posedge clk_53p6) disable iff (!arst_n)
		(rot1_q < ikari_input_pkg::rot_positions) &&
		(rot2_q < ikari_input_pkg::rot_positions));

endmodule

// ==== rtl/dip_switch_bank.sv ====
// DIP switch bank capturing DIP and game bytes from the download stream
`timescale 1ns/1ps

module dip_switch_bank (
	input  logic        clk_53p6,
	input  logic        arst_n,
	input  logic        ioctl_wr,
	input  logic [7:0]  ioctl_index,
	input  logic [24:0] ioctl_addr,
	input  logic [7:0]  ioctl_dout,
	output logic [15:0] dsw,
	output logic [7:0]  game
);

	// Eight DIP bytes as the menu sends them
	logic [7:0] sw_q [ikari_input_pkg::dip_bytes];
	logic       dip_wr;
	logic       game_wr;

	// Strobes for each destination
	assign dip_wr  = ioctl_wr && (ioctl_index == ikari_input_pkg::dip_index) &&
	                 (ioctl_addr < 25'(ikari_input_pkg::dip_bytes));
	assign game_wr = ioctl_wr && (ioctl_index == ikari_input_pkg::game_index) &&
	                 (ioctl_addr == '0);

	// Slot picked by the low address bits
	always_ff @(posedge clk_53p6 or negedge arst_n) begin
		if (!arst_n) begin
			for (int i = 0; i < ikari_input_pkg::dip_bytes; i++)
				sw_q[i] <= '0;
			game <= '0;
		end else begin
			if (dip_wr)
				sw_q[ioctl_addr[2:0]] <= ioctl_dout;
			if (game_wr)
				game <= ioctl_dout;
		end
	end

	// Core only reads the first two banks
	assign dsw = {sw_q[1], sw_q[0]};

	// Game byte moves only as the result of its own write
	a_game_src: assert property (@(posedge clk_53p6) disable iff (!arst_n)
		!$stable(game) |-> $past(game_wr));

endmodule

// ==== rtl/ikari_input_pkg.sv ====
// Ikari Warriors input block package with widths, indexes, enums and bit positions
package ikari_input_pkg;

	// ========================================================================
	// Widths and counts
	// ========================================================================
	// Gamepad word and player word share one width
	localparam int joy_w         = 16;
	localparam int rot_positions = 12;
	localparam int rot_w         = 4;
	// Rotary position after reset
	localparam logic [rot_w-1:0] rot_home = 4'd11;

	// Download stream indexes
	localparam logic [7:0] dip_index  = 8'd254;
	localparam logic [7:0] game_index = 8'd1;
	localparam int         dip_bytes  = 8;

	// ========================================================================
	// Enums
	// ========================================================================
	typedef enum logic {
		src_usb  = 1'b0,
		src_db15 = 1'b1
	} joy_src_e;

	// Left steps up (ccw), right steps down (cw)
	typedef enum logic [1:0] {
		rot_hold = 2'd0,
		rot_ccw  = 2'd1,
		rot_cw   = 2'd2
	} rot_dir_e;

	// ========================================================================
	// Bit positions
	// ========================================================================
	// USB gamepad word, active high
	localparam int usb_right = 0, usb_left = 1, usb_down = 2, usb_up = 3;
	localparam int usb_shot = 4, usb_grenade = 5, usb_start = 6, usb_coin = 7;
	localparam int usb_rot_left = 8, usb_rot_right = 9, usb_service = 10, usb_pause = 11;

	// DB15 word, NeoGeo button layout, active high
	localparam int db_right = 0, db_left = 1, db_down = 2, db_up = 3;
	localparam int db_a = 4, db_b = 5, db_c = 6, db_d = 7;
	localparam int db_start = 10, db_select = 11;

	// Player word read by the core, active low buttons, bits 8, 14, 15 tied high
	localparam int pw_coin = 0, pw_start = 1, pw_shot = 2, pw_grenade = 3;
	localparam int pw_rot_lo = 4, pw_rot_hi = 7;
	localparam int pw_service = 9, pw_left = 10, pw_right = 11, pw_down = 12, pw_up = 13;

endpackage

// ==== rtl/ikari_input_top.sv ====
// Ikari Warriors input top joining source mappers, cabinet panel and DIP bank
`timescale 1ns/1ps

module ikari_input_top #(
	parameter int rot_div_w = 23
) (
	input  logic        clk_53p6,
	input  logic        arst_n,
	// Gamepad words
	input  logic [15:0] joy_usb_1,
	input  logic [15:0] joy_usb_2,
	input  logic [15:0] joy_db15_1,
	input  logic [15:0] joy_db15_2,
	// Per-player DB15 select
	input  logic [1:0]  snac_db15,
	// Download stream
	input  logic        ioctl_wr,
	input  logic [7:0]  ioctl_index,
	input  logic [24:0] ioctl_addr,
	input  logic [7:0]  ioctl_dout,
	// To the game core
	output logic [15:0] player1,
	output logic [15:0] player2,
	output logic        pause_req,
	output logic [15:0] dsw,
	output logic [7:0]  game
);

	// ========================================================================
	// Per-player decode
	// ========================================================================
	player_ctrl_if p1_ctrl ();
	player_ctrl_if p2_ctrl ();

	joy_source_mapper p1_map_i (
		.src      (ikari_input_pkg::joy_src_e'(snac_db15[0])),
		.joy_usb  (joy_usb_1),
		.joy_db15 (joy_db15_1),
		.ctrl     (p1_ctrl)
	);

	joy_source_mapper p2_map_i (
		.src      (ikari_input_pkg::joy_src_e'(snac_db15[1])),
		.joy_usb  (joy_usb_2),
		.joy_db15 (joy_db15_2),
		.ctrl     (p2_ctrl)
	);

	// ========================================================================
	// Panel and DIP capture
	// ========================================================================
	cabinet_panel #(
		.rot_div_w (rot_div_w)
	) panel_i (
		.clk_53p6  (clk_53p6),
		.arst_n    (arst_n),
		.p1        (p1_ctrl),
		.p2        (p2_ctrl),
		.player1   (player1),
		.player2   (player2),
		.pause_req (pause_req)
	);

	dip_switch_bank dip_i (
		.clk_53p6    (clk_53p6),
		.arst_n      (arst_n),
		.ioctl_wr    (ioctl_wr),
		.ioctl_index (ioctl_index),
		.ioctl_addr  (ioctl_addr),
		.ioctl_dout  (ioctl_dout),
		.dsw         (dsw),
		.game        (game)
	);

endmodule

// ==== rtl/joy_source_mapper.sv ====
// Joystick source mapper choosing USB or DB15 and decoding to active-high controls
`timescale 1ns/1ps

module joy_source_mapper (
	input  ikari_input_pkg::joy_src_e                src,
	input  logic [ikari_input_pkg::joy_w-1:0]        joy_usb,
	input  logic [ikari_input_pkg::joy_w-1:0]        joy_db15,
	player_ctrl_if.src                               ctrl
);

	// ========================================================================
	// Source decode, purely combinational
	// ========================================================================
	always_comb begin
		if (src == ikari_input_pkg::src_db15) begin
			// Directions map one to one
			ctrl.up        = joy_db15[ikari_input_pkg::db_up];
			ctrl.down      = joy_db15[ikari_input_pkg::db_down];
			ctrl.left      = joy_db15[ikari_input_pkg::db_left];
			ctrl.right     = joy_db15[ikari_input_pkg::db_right];
			// B fires, C throws
			ctrl.shot      = joy_db15[ikari_input_pkg::db_b];
			ctrl.grenade   = joy_db15[ikari_input_pkg::db_c];
			ctrl.start     = joy_db15[ikari_input_pkg::db_start];
			// Select doubles as coin
			ctrl.coin      = joy_db15[ikari_input_pkg::db_select];
			// A and D turn the rotary
			ctrl.rot_left  = joy_db15[ikari_input_pkg::db_a];
			ctrl.rot_right = joy_db15[ikari_input_pkg::db_d];
			// Combos on select since the pad has no spare buttons
			ctrl.service   = joy_db15[ikari_input_pkg::db_select] &
			                 joy_db15[ikari_input_pkg::db_b];
			ctrl.pause     = joy_db15[ikari_input_pkg::db_select] &
			                 joy_db15[ikari_input_pkg::db_a];
		end else begin
			// USB word already in control order
			ctrl.up        = joy_usb[ikari_input_pkg::usb_up];
			ctrl.down      = joy_usb[ikari_input_pkg::usb_down];
			ctrl.left      = joy_usb[ikari_input_pkg::usb_left];
			ctrl.right     = joy_usb[ikari_input_pkg::usb_right];
			ctrl.shot      = joy_usb[ikari_input_pkg::usb_shot];
			ctrl.grenade   = joy_usb[ikari_input_pkg::usb_grenade];
			ctrl.start     = joy_usb[ikari_input_pkg::usb_start];
			ctrl.coin      = joy_usb[ikari_input_pkg::usb_coin];
			ctrl.rot_left  = joy_usb[ikari_input_pkg::usb_rot_left];
			ctrl.rot_right = joy_usb[ikari_input_pkg::usb_rot_right];
			ctrl.service   = joy_usb[ikari_input_pkg::usb_service];
			ctrl.pause     = joy_usb[ikari_input_pkg::usb_pause];
		end
	end

endmodule

// ==== rtl/player_ctrl_if.sv ====
// Player control interface carrying one player's decoded active-high controls
`timescale 1ns/1ps

interface player_ctrl_if;

	// Directions
	logic up;
	logic down;
	logic left;
	logic right;
	// Buttons
	logic shot;
	logic grenade;
	logic start;
	logic coin;
	logic service;
	// Rotary step requests, held levels
	logic rot_left;
	logic rot_right;
	logic pause;

	// Source side, driven by the mapper
	modport src (
		output up, down, left, right, shot, grenade, start, coin,
		output service, rot_left, rot_right, pause
	);

	// Sink side, read by the panel
	modport snk (
		input up, down, left, right, shot, grenade, start, coin,
		input service, rot_left, rot_right, pause
	);

endinterface

// ==== run.sh ====
#!/bin/sh
# Build and run the testbench, the log decides pass or fail
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal -f project.f \
	--top-module tb_ikari_input -Mdir obj_dir -o tb_ikari_input \
	&& ./obj_dir/tb_ikari_input > sim.log 2>&1 \
	|| echo "Build or simulation ended abnormally"
cat sim.log 2>/dev/null
grep -q "^Verification passed$" sim.log && exit 0 || exit 1

// ==== verif/tb_ikari_ref.svh ====
// Reference model of the player word and the rotary step for the input testbench
`ifndef tb_ikari_ref_svh
`define tb_ikari_ref_svh

// Expected player word with buttons active low and bits 8, 14, 15 high
function automatic logic [15:0] ref_player_word(input logic src, input logic [15:0] usb,
                                                input logic [15:0] db, input logic [3:0] rot);
	logic [15:0] w;
	w      = 16'hffff;
	w[7:4] = rot;
	if (src) begin
		// B shoots, C throws, select is coin, select with B is service
		w[0]     = ~db[11];
		w[1]     = ~db[10];
		w[2]     = ~db[5];
		w[3]     = ~db[6];
		w[9]     = ~(db[11] & db[5]);
		// Up, down, right, left from bit 13 down
		w[13:10] = ~{db[3], db[2], db[0], db[1]};
	end else begin
		w[0]     = ~usb[7];
		w[1]     = ~usb[6];
		w[2]     = ~usb[4];
		w[3]     = ~usb[5];
		w[9]     = ~usb[10];
		w[13:10] = ~{usb[3], usb[2], usb[0], usb[1]};
	end
	return w;
endfunction

// Next dial position, left counts up and wins over right
function automatic logic [3:0] ref_rot_step(input logic [3:0] cur, input logic left,
                                            input logic right);
	if (left)
		return (cur == 4'd11) ? 4'd0 : cur + 4'd1;
	if (right)
		return (cur == 4'd0) ? 4'd11 : cur - 4'd1;
	return cur;
endfunction

`endif

// ==== verif/tb_ikari_input.sv ====
// Testbench for the Ikari Warriors player input block
`timescale 1ns/1ps

module tb_ikari_input;

	localparam int clk_period   = 4;
	localparam int tb_rot_div_w = 4;
	localparam int vectors      = 200;
	// Rotary waits dominate, up to 27 steps of one divider period
	localparam int test_cycles  = 2 * vectors + 27 * (1 << tb_rot_div_w) + 60;

	logic        clk_53p6;
	logic        arst_n;
	logic [15:0] joy_usb_1, joy_usb_2, joy_db15_1, joy_db15_2;
	logic [1:0]  snac_db15;
	logic        ioctl_wr;
	logic [7:0]  ioctl_index;
	logic [24:0] ioctl_addr;
	logic [7:0]  ioctl_dout;
	logic [15:0] player1, player2, dsw;
	logic        pause_req;
	logic [7:0]  game;

	// Expected state kept beside the DUT
	logic [31:0] rng_state;
	logic [31:0] rnd;
	logic [3:0]  exp_rot1, exp_rot2;
	logic [7:0]  dip_exp [8];
	logic [7:0]  game_exp;
	logic        cmp_en;
	bit          changed, wrapped;
	int          check_count, error_count;

	`include "tb_ikari_ref.svh"

	ikari_input_top #(
		.rot_div_w (tb_rot_div_w)
	) dut_i (.*);

	// ========================================================================
	// Helpers
	// ========================================================================
	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic draw_random(output logic [31:0] r);
		rng_state = xorshift32(rng_state);
		r = rng_state;
	endtask

	// Pause per player, select with A on DB15
	function automatic logic ref_pause(input logic src, input logic [15:0] usb,
	                                   input logic [15:0] db);
		return src ? (db[11] & db[4]) : usb[11];
	endfunction

	task automatic report_mismatch(input string name, input logic [31:0] got,
	                               input logic [31:0] expd);
		error_count++;
		$display("error %s got 0x%0h expected 0x%0h", name, got, expd);
	endtask

	// Words and pause against the inputs held before the last rising edge
	task automatic check_words();
		logic [15:0] exp1;
		logic [15:0] exp2;
		logic        expp;
		exp1 = ref_player_word(snac_db15[0], joy_usb_1, joy_db15_1, exp_rot1);
		exp2 = ref_player_word(snac_db15[1], joy_usb_2, joy_db15_2, exp_rot2);
		expp = ref_pause(snac_db15[0], joy_usb_1, joy_db15_1) |
		       ref_pause(snac_db15[1], joy_usb_2, joy_db15_2);
		check_count += 3;
		if (player1 !== exp1)
			report_mismatch("player1", 32'(player1), 32'(exp1));
		if (player2 !== exp2)
			report_mismatch("player2", 32'(player2), 32'(exp2));
		if (pause_req !== expp)
			report_mismatch("pause_req", 32'(pause_req), 32'(expp));
	endtask

	task automatic check_dip();
		check_count += 2;
		if (dsw !== {dip_exp[1], dip_exp[0]})
			report_mismatch("dsw", 32'(dsw), 32'({dip_exp[1], dip_exp[0]}));
		if (game !== game_exp)
			report_mismatch("game", 32'(game), 32'(game_exp));
	endtask

	// Ends on a change of the player 1 rot field, bounded by two divider periods
	task automatic wait_rot_change(output bit moved);
		logic [3:0] prev;
		int         n;
		prev  = player1[7:4];
		moved = 1'b0;
		n     = 0;
		while (!moved && n < 2 * (1 << tb_rot_div_w)) begin
			@(posedge clk_53p6);
			#1;
			moved = (player1[7:4] != prev);
			n++;
		end
		if (!moved) begin
			error_count++;
			$display("Rotary field of player1 did not move within %0d cycles", n);
		end
	endtask

	// One byte of the download stream, strobe held for one clock
	task automatic download_byte(input logic [7:0] index, input logic [24:0] addr,
	                             input logic [7:0] data);
		@(negedge clk_53p6);
		ioctl_wr    = 1'b1;
		ioctl_index = index;
		ioctl_addr  = addr;
		ioctl_dout  = data;
		@(negedge clk_53p6);
		ioctl_wr = 1'b0;
	endtask

	// ========================================================================
	// Clock, compare process and watchdog
	// ========================================================================
	initial begin
		clk_53p6 = 1'b0;
		forever #(clk_period / 2) clk_53p6 = ~clk_53p6;
	end

	// Outputs have settled 1 ns after the edge, inputs move only on the falling edge
	initial begin
		forever begin
			@(posedge clk_53p6);
			#1;
			if (cmp_en)
				check_words();
		end
	end

	initial begin
		#(2 * test_cycles * clk_period);
		$display("Watchdog expired after %0d cycles before the tests finished",
		         2 * test_cycles);
		$display("checks %0d errors %0d", check_count, error_count);
		$display("Verification failed");
		$finish;
	end

	// ========================================================================
	// Stimulus
	// ========================================================================
	initial begin
		arst_n      = 1'b0;
		joy_usb_1   = '0;
		joy_usb_2   = '0;
		joy_db15_1  = '0;
		joy_db15_2  = '0;
		snac_db15   = 2'b00;
		ioctl_wr    = 1'b0;
		ioctl_index = '0;
		ioctl_addr  = '0;
		ioctl_dout  = '0;
		cmp_en      = 1'b0;
		check_count = 0;
		error_count = 0;
		rng_state   = 32'h83ac_8739;
		exp_rot1    = 4'd11;
		exp_rot2    = 4'd11;
		game_exp    = '0;
		for (int i = 0; i < 8; i++)
			dip_exp[i] = '0;
		repeat (3) @(posedge clk_53p6);
		@(negedge clk_53p6);
		// Released words with the dial at 11, all captures empty
		check_count += 5;
		if (player1 !== 16'hffbf)
			report_mismatch("player1", 32'(player1), 32'hffbf);
		if (player2 !== 16'hffbf)
			report_mismatch("player2", 32'(player2), 32'hffbf);
		if (pause_req !== 1'b0)
			report_mismatch("pause_req", 32'(pause_req), 32'h0);
		if (dsw !== 16'h0)
			report_mismatch("dsw", 32'(dsw), 32'h0);
		if (game !== 8'h0)
			report_mismatch("game", 32'(game), 32'h0);
		arst_n = 1'b1;

		// USB only, rotate bits held low
		for (int i = 0; i < vectors; i++) begin
			@(negedge clk_53p6);
			draw_random(rnd);
			joy_usb_1 = rnd[15:0] & 16'hfcff;
			joy_usb_2 = rnd[31:16] & 16'hfcff;
			cmp_en    = 1'b1;
		end

		// Mixed sources, A and D masked so the dial stays put
		for (int i = 0; i < vectors; i++) begin
			@(negedge clk_53p6);
			draw_random(rnd);
			joy_db15_1 = rnd[15:0] & 16'hff6f;
			joy_db15_2 = rnd[31:16] & 16'hff6f;
			draw_random(rnd);
			joy_usb_1  = rnd[15:0] & 16'hfcff;
			joy_usb_2  = rnd[31:16] & 16'hfcff;
			snac_db15  = rnd[9:8];
		end

		// Rotary left for 14 steps, must pass 11 to 0
		@(negedge clk_53p6);
		cmp_en     = 1'b0;
		snac_db15  = 2'b00;
		joy_db15_1 = 16'h0000;
		joy_db15_2 = 16'h0000;
		joy_usb_1  = 16'h0100;
		joy_usb_2  = 16'h0100;
		wrapped    = 1'b0;
		for (int i = 0; i < 14; i++) begin
			wait_rot_change(changed);
			if (!changed)
				break;
			if (exp_rot1 == 4'd11)
				wrapped = 1'b1;
			exp_rot1 = ref_rot_step(exp_rot1, 1'b1, 1'b0);
			exp_rot2 = ref_rot_step(exp_rot2, 1'b1, 1'b0);
			check_words();
		end
		if (!wrapped) begin
			error_count++;
			$display("Rotary did not wrap from 11 to 0 turning left");
		end

		// Rotary right until 0 wraps to 11
		@(negedge clk_53p6);
		joy_usb_1 = 16'h0200;
		joy_usb_2 = 16'h0200;
		wrapped   = 1'b0;
		for (int i = 0; i < 13 && !wrapped; i++) begin
			wait_rot_change(changed);
			if (!changed)
				break;
			if (exp_rot1 == 4'd0)
				wrapped = 1'b1;
			exp_rot1 = ref_rot_step(exp_rot1, 1'b0, 1'b1);
			exp_rot2 = ref_rot_step(exp_rot2, 1'b0, 1'b1);
			check_words();
		end
		if (!wrapped) begin
			error_count++;
			$display("Rotary did not wrap from 0 to 11 turning right");
		end

		// Select with A on player 1 and select with B on player 2 for one clock
		// Held just after a step so the divider cannot tick meanwhile
		@(negedge clk_53p6);
		snac_db15  = 2'b11;
		joy_usb_1  = 16'h0000;
		joy_usb_2  = 16'h0000;
		joy_db15_1 = 16'h0810;
		joy_db15_2 = 16'h0820;
		@(posedge clk_53p6);
		#1;
		check_words();
		@(negedge clk_53p6);
		snac_db15  = 2'b00;
		joy_db15_1 = 16'h0000;
		joy_db15_2 = 16'h0000;
		@(posedge clk_53p6);
		#1;
		check_words();

		// DIP bytes at every slot, then writes that must be ignored
		for (int a = 0; a < 8; a++) begin
			draw_random(rnd);
			download_byte(ikari_input_pkg::dip_index, 25'(a), rnd[7:0]);
			dip_exp[a] = rnd[7:0];
			check_dip();
		end
		download_byte(8'd253, 25'd1, ~dip_exp[1]);
		check_dip();
		// Address 8 would land in slot 0 if the range were ignored
		download_byte(ikari_input_pkg::dip_index, 25'd8, ~dip_exp[0]);
		check_dip();
		// Game byte only from address zero
		draw_random(rnd);
		game_exp = rnd[7:0] | 8'h01;
		download_byte(ikari_input_pkg::game_index, 25'd0, game_exp);
		check_dip();
		download_byte(ikari_input_pkg::game_index, 25'd1, ~game_exp);
		check_dip();

		@(negedge clk_53p6);
		$display("checks %0d errors %0d", check_count, error_count);
		if (error_count == 0)
			$display("Verification passed");
		else
			$display("Verification failed");
		$finish;
	end

endmodule
